//--- src/gfx_pkg.sv
// Shared types and widths for the graphics subsystem; referenced by scoped name from each block
`default_nettype none

package gfx_pkg;

  // ####################################################################
  // Field widths
  // ####################################################################

  localparam int COLOR_WIDTH = 4;
  localparam int COORD_WIDTH = 10;

  // Stored and displayed colour
  typedef struct packed {
    logic [COLOR_WIDTH-1:0] red;
    logic [COLOR_WIDTH-1:0] grn;
    logic [COLOR_WIDTH-1:0] blu;
  } pixel_t;

  typedef enum logic [1:0] {
    op_clear = 2'd0,
    op_fill  = 2'd1,
    op_frame = 2'd2
  } gfx_op_e;

  // One host drawing command, corners inclusive
  typedef struct packed {
    gfx_op_e                op;
    logic [COORD_WIDTH-1:0] x0;
    logic [COORD_WIDTH-1:0] y0;
    logic [COORD_WIDTH-1:0] x1;
    logic [COORD_WIDTH-1:0] y1;
    pixel_t                 color;
  } draw_cmd_t;

  // Timing generator output, syncs active low
  typedef struct packed {
    logic                   hsync;
    logic                   vsync;
    logic                   active;
    logic [COORD_WIDTH-1:0] x;
    logic [COORD_WIDTH-1:0] y;
  } vga_pos_t;

  typedef struct packed {
    logic   hsync;
    logic   vsync;
    logic   de;
    pixel_t rgb;
  } vga_out_t;

endpackage

`default_nettype wire

//--- src/vga_timing.sv
// Raster timing generator; produces registered syncs, active flag and pixel position for the mode
`timescale 1ns/1ns
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic              pixel_clk,
    input  logic              rst_n,
    output gfx_pkg::vga_pos_t pos
);
  localparam int CW = gfx_pkg::COORD_WIDTH;

  // Horizontal landmarks
  localparam logic [CW-1:0] H_VIS_END    = CW'(H_ACTIVE);
  localparam logic [CW-1:0] H_SYNC_START = CW'(H_ACTIVE + H_FRONT);
  localparam logic [CW-1:0] H_SYNC_END   = CW'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam logic [CW-1:0] H_LAST       = CW'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

  // Vertical landmarks
  localparam logic [CW-1:0] V_VIS_END    = CW'(V_ACTIVE);
  localparam logic [CW-1:0] V_SYNC_START = CW'(V_ACTIVE + V_FRONT);
  localparam logic [CW-1:0] V_SYNC_END   = CW'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam logic [CW-1:0] V_LAST       = CW'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

  logic [CW-1:0] h_cnt;
  logic [CW-1:0] v_cnt;
  logic          h_last;
  logic          v_last;

  assign h_last = (h_cnt == H_LAST);
  assign v_last = (v_cnt == V_LAST);

  // ####################################################################
  // Counters
  // ####################################################################

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      if (v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // Decoded outputs, one register stage after the counters
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      pos.hsync  <= 1'b1;
      pos.vsync  <= 1'b1;
      pos.active <= 1'b0;
      pos.x      <= '0;
      pos.y      <= '0;
    end else begin
      pos.hsync  <= !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
      pos.vsync  <= !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
      pos.active <= (h_cnt < H_VIS_END) && (v_cnt < V_VIS_END);
      pos.x      <= h_cnt;
      pos.y      <= v_cnt;
    end
  end

endmodule

`default_nettype wire

//--- src/shape_raster.sv
// Command rasterizer; accepts req/ack drawing commands and issues clipped framebuffer writes
`timescale 1ns/1ns
`default_nettype none

module shape_raster #(
    parameter  int H_ACTIVE   = 640,
    parameter  int V_ACTIVE   = 480,
    localparam int ADDR_WIDTH = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  logic                   pixel_clk,
    input  logic                   rst_n,

    input  logic                   cmd_req,
    input  gfx_pkg::draw_cmd_t     cmd,
    output logic                   cmd_ack,

    output logic                   wr_req,
    output logic [ADDR_WIDTH-1:0]  wr_addr,
    output gfx_pkg::pixel_t        wr_data,
    input  logic                   wr_grant
);
  localparam int CW = gfx_pkg::COORD_WIDTH;

  localparam logic [CW-1:0]         X_MAX    = CW'(H_ACTIVE - 1);
  localparam logic [CW-1:0]         Y_MAX    = CW'(V_ACTIVE - 1);
  localparam logic [ADDR_WIDTH-1:0] ROW_STEP = ADDR_WIDTH'(H_ACTIVE);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_draw,
    st_ack
  } state_e;

  state_e state;

  gfx_pkg::draw_cmd_t cmd_q;

  // Clipped bounds
  logic [CW-1:0] cx0;
  logic [CW-1:0] cx1;
  logic [CW-1:0] cy0;
  logic [CW-1:0] cy1;

  logic [CW-1:0]         x_cnt;
  logic [CW-1:0]         y_cnt;
  logic [ADDR_WIDTH-1:0] row_base;

  logic empty;
  logic row_end;
  logic last_row;
  logic edge_row;

  // ####################################################################
  // Clipping
  // ####################################################################

  always_comb begin
    if (cmd_q.op == gfx_pkg::op_clear) begin
      cx0 = '0;
      cy0 = '0;
      cx1 = X_MAX;
      cy1 = Y_MAX;
    end else begin
      cx0 = cmd_q.x0;
      cy0 = cmd_q.y0;
      cx1 = (cmd_q.x1 > X_MAX) ? X_MAX : cmd_q.x1;
      cy1 = (cmd_q.y1 > Y_MAX) ? Y_MAX : cmd_q.y1;
    end
  end

  // Also catches a rectangle starting fully off screen
  assign empty    = (cx0 > cx1) || (cy0 > cy1);
  assign row_end  = (x_cnt == cx1);
  assign last_row = (y_cnt == cy1);
  assign edge_row = (y_cnt == cy0) || last_row;

  assign cmd_ack = (state == st_ack);
  assign wr_req  = (state == st_draw);
  assign wr_addr = row_base + ADDR_WIDTH'(x_cnt);
  assign wr_data = cmd_q.color;

  always_ff @(posedge pixel_clk) begin
    if (state == st_idle && cmd_req) begin
      cmd_q <= cmd;
    end
  end

  // ####################################################################
  // Command FSM
  // ####################################################################

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      x_cnt    <= '0;
      y_cnt    <= '0;
      row_base <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (cmd_req) begin
            y_cnt    <= '0;
            row_base <= '0;
            state    <= st_setup;
          end
        end

        // Step the row base down to the first row, one add per cycle
        st_setup: begin
          if (empty) begin
            state <= st_ack;
          end else if (y_cnt != cy0) begin
            y_cnt    <= y_cnt + 1'b1;
            row_base <= row_base + ROW_STEP;
          end else begin
            x_cnt <= cx0;
            state <= st_draw;
          end
        end

        st_draw: begin
          if (wr_grant) begin
            if (row_end) begin
              if (last_row) begin
                state <= st_ack;
              end else begin
                x_cnt    <= cx0;
                y_cnt    <= y_cnt + 1'b1;
                row_base <= row_base + ROW_STEP;
              end
            end else if (cmd_q.op == gfx_pkg::op_frame && !edge_row) begin
              // Outline interior rows jump to the right edge
              x_cnt <= cx1;
            end else begin
              x_cnt <= x_cnt + 1'b1;
            end
          end
        end

        st_ack: begin
          if (!cmd_req) begin
            state <= st_idle;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/framebuffer.sv
// Single-port pixel store; scanout reads take the port and drawing writes fill the gaps
`timescale 1ns/1ns
`default_nettype none

module framebuffer #(
    parameter  int H_ACTIVE   = 640,
    parameter  int V_ACTIVE   = 480,
    localparam int DEPTH      = H_ACTIVE * V_ACTIVE,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input  logic                  pixel_clk,

    // Read side, data one cycle later
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output gfx_pkg::pixel_t       rd_data,

    // Write side
    input  logic                  wr_req,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  gfx_pkg::pixel_t       wr_data,
    output logic                  wr_grant
);

  gfx_pkg::pixel_t mem[DEPTH];

  // Write only goes through when the port is free
  assign wr_grant = wr_req && !rd_en;

  // ####################################################################
  // Port
  // ####################################################################

  always_ff @(posedge pixel_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end else if (wr_req) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- src/scanout.sv
// Video scanout; reads the framebuffer in raster order and aligns syncs and enable with the data
`timescale 1ns/1ns
`default_nettype none

module scanout #(
    parameter  int H_ACTIVE   = 640,
    parameter  int V_ACTIVE   = 480,
    localparam int ADDR_WIDTH = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  logic                  pixel_clk,
    input  logic                  rst_n,

    input  gfx_pkg::vga_pos_t     pos,

    output logic                  rd_en,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    input  gfx_pkg::pixel_t       rd_data,

    output gfx_pkg::vga_out_t     video
);
  localparam int CW = gfx_pkg::COORD_WIDTH;

  localparam logic [CW-1:0] V_VIS_END = CW'(V_ACTIVE);

  logic [ADDR_WIDTH-1:0] addr_cnt;

  logic hsync_q;
  logic vsync_q;
  logic de_q;

  // ####################################################################
  // Read address
  // ####################################################################

  assign rd_en   = pos.active;
  assign rd_addr = addr_cnt;

  // Restarts during vertical blanking
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      addr_cnt <= '0;
    end else if (pos.y >= V_VIS_END) begin
      addr_cnt <= '0;
    end else if (pos.active) begin
      addr_cnt <= addr_cnt + 1'b1;
    end
  end

  // ####################################################################
  // Output alignment
  // ####################################################################

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
      de_q    <= 1'b0;
    end else begin
      hsync_q <= pos.hsync;
      vsync_q <= pos.vsync;
      de_q    <= pos.active;
    end
  end

  // Black outside the visible area
  always_comb begin
    video.hsync = hsync_q;
    video.vsync = vsync_q;
    video.de    = de_q;
    video.rgb   = de_q ? rd_data : '0;
  end

endmodule

`default_nettype wire

//--- src/gfx_shapes_top.sv
// Graphics subsystem top; set the video mode here and drive commands on the req/ack port
`timescale 1ns/1ns
`default_nettype none

module gfx_shapes_top #(
    parameter  int H_ACTIVE   = 640,
    parameter  int H_FRONT    = 16,
    parameter  int H_SYNC     = 96,
    parameter  int H_BACK     = 48,
    parameter  int V_ACTIVE   = 480,
    parameter  int V_FRONT    = 10,
    parameter  int V_SYNC     = 2,
    parameter  int V_BACK     = 33,
    localparam int ADDR_WIDTH = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  logic               pixel_clk,
    input  logic               rst_n,

    input  logic               cmd_req,
    input  gfx_pkg::draw_cmd_t cmd,
    output logic               cmd_ack,

    output gfx_pkg::vga_out_t  video
);

  gfx_pkg::vga_pos_t     pos;

  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  gfx_pkg::pixel_t       rd_data;

  logic                  wr_req;
  logic [ADDR_WIDTH-1:0] wr_addr;
  gfx_pkg::pixel_t       wr_data;
  logic                  wr_grant;

  vga_timing #(
      .H_ACTIVE(H_ACTIVE),
      .H_FRONT (H_FRONT),
      .H_SYNC  (H_SYNC),
      .H_BACK  (H_BACK),
      .V_ACTIVE(V_ACTIVE),
      .V_FRONT (V_FRONT),
      .V_SYNC  (V_SYNC),
      .V_BACK  (V_BACK)
  ) vga_timing_i (
      .pixel_clk(pixel_clk),
      .rst_n    (rst_n),
      .pos      (pos)
  );

  shape_raster #(
      .H_ACTIVE(H_ACTIVE),
      .V_ACTIVE(V_ACTIVE)
  ) shape_raster_i (
      .pixel_clk(pixel_clk),
      .rst_n    (rst_n),
      .cmd_req  (cmd_req),
      .cmd      (cmd),
      .cmd_ack  (cmd_ack),
      .wr_req   (wr_req),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_grant (wr_grant)
  );

  framebuffer #(
      .H_ACTIVE(H_ACTIVE),
      .V_ACTIVE(V_ACTIVE)
  ) framebuffer_i (
      .pixel_clk(pixel_clk),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .wr_req   (wr_req),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_grant (wr_grant)
  );

  scanout #(
      .H_ACTIVE(H_ACTIVE),
      .V_ACTIVE(V_ACTIVE)
  ) scanout_i (
      .pixel_clk(pixel_clk),
      .rst_n    (rst_n),
      .pos      (pos),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .video    (video)
  );

endmodule

`default_nettype wire

//--- bench/tb_gfx_shapes.sv
// Testbench for the graphics top; replays bench/gfx_input.txt against a model and checks video
`timescale 1ns/1ns
`default_nettype none

module tb_gfx_shapes;

  localparam int H_ACTIVE     = 32;
  localparam int V_ACTIVE     = 24;
  localparam int V_TOTAL      = V_ACTIVE + 1 + 2 + 1;
  localparam int FRAME_CYCLES = (H_ACTIVE + 2 + 3 + 2) * V_TOTAL;
  localparam int NPIX         = H_ACTIVE * V_ACTIVE;
  localparam int WAIT_LIMIT   = 20 * FRAME_CYCLES;

  logic               pixel_clk;
  logic               rst_n;
  logic               cmd_req;
  gfx_pkg::draw_cmd_t cmd;
  logic               cmd_ack;
  gfx_pkg::vga_out_t  video;

  // Model of the screen and the last captured frame
  logic [11:0] ref_fb[NPIX];
  logic [11:0] cap_fb[NPIX];

  gfx_shapes_top #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(2), .H_SYNC(3), .H_BACK(2),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(1), .V_SYNC(2), .V_BACK(1)
  ) uut (
      .pixel_clk(pixel_clk),
      .rst_n    (rst_n),
      .cmd_req  (cmd_req),
      .cmd      (cmd),
      .cmd_ack  (cmd_ack),
      .video    (video)
  );

  always begin
    pixel_clk = 1'b0;
    #50;
    pixel_clk = 1'b1;
    #50;
  end

  // ####################################################################
  // Helpers
  // ####################################################################

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("error %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task automatic check_idle_outputs(input string phase);
    check({phase, "_cmd_ack"}, 0, cmd_ack);
    check({phase, "_hsync"}, 1, video.hsync);
    check({phase, "_vsync"}, 1, video.vsync);
    check({phase, "_de"}, 0, video.de);
    check({phase, "_rgb"}, 0, video.rgb);
  endtask

  // Clip, then paint; returns the number of pixels written
  function automatic int paint_model(input gfx_pkg::draw_cmd_t c);
    int xa;
    int ya;
    int xb;
    int yb;
    int n;
    xa = (c.op == gfx_pkg::op_clear) ? 0 : int'(c.x0);
    ya = (c.op == gfx_pkg::op_clear) ? 0 : int'(c.y0);
    xb = (c.op == gfx_pkg::op_clear || c.x1 >= H_ACTIVE) ? H_ACTIVE - 1 : int'(c.x1);
    yb = (c.op == gfx_pkg::op_clear || c.y1 >= V_ACTIVE) ? V_ACTIVE - 1 : int'(c.y1);
    n = 0;
    for (int y = ya; y <= yb; y++) begin
      for (int x = xa; x <= xb; x++) begin
        if (c.op != gfx_pkg::op_frame || x == xa || x == xb || y == ya || y == yb) begin
          ref_fb[y * H_ACTIVE + x] = c.color;
          n++;
        end
      end
    end
    return n;
  endfunction

  task automatic send_command(input gfx_pkg::draw_cmd_t c, input int pixels);
    int cycles;
    int gap;
    check("ack_before_req", 0, cmd_ack);
    cmd     = c;
    cmd_req = 1'b1;
    cycles  = 0;
    while (cmd_ack !== 1'b1) begin
      if (cycles == WAIT_LIMIT) stop_run("timeout while waiting for cmd_ack to rise");
      @(negedge pixel_clk);
      cycles++;
    end
    check("ack_latency_min", 1, cycles >= pixels + 2);
    cmd_req = 1'b0;
    cycles  = 0;
    while (cmd_ack !== 1'b0) begin
      if (cycles == WAIT_LIMIT) stop_run("timeout while waiting for cmd_ack to fall");
      @(negedge pixel_clk);
      cycles++;
    end
    gap = $urandom % 8;
    repeat (gap) begin
      @(negedge pixel_clk);
      check("ack_idle", 0, cmd_ack);
    end
  endtask

  // Grab one frame starting at the end of a vsync pulse
  task automatic capture_frame();
    int   cycles;
    int   idx;
    int   run;
    int   de_lines;
    int   hs_falls;
    int   vs_falls;
    logic prev_de;
    logic prev_hs;
    logic prev_vs;
    cycles = 0;
    while (video.vsync !== 1'b0) begin
      if (cycles == 2 * FRAME_CYCLES) stop_run("timeout while waiting for vsync to go low");
      @(negedge pixel_clk);
      cycles++;
    end
    cycles = 0;
    while (video.vsync !== 1'b1) begin
      if (cycles == 2 * FRAME_CYCLES) stop_run("timeout while waiting for vsync to go high");
      @(negedge pixel_clk);
      cycles++;
    end
    idx      = 0;
    run      = 0;
    de_lines = 0;
    hs_falls = 0;
    vs_falls = 0;
    prev_de  = 1'b0;
    prev_hs  = video.hsync;
    prev_vs  = 1'b1;
    repeat (FRAME_CYCLES) begin
      if (video.de) begin
        if (idx < NPIX) cap_fb[idx] = video.rgb;
        idx++;
        run++;
      end else begin
        check("rgb_in_blanking", 0, video.rgb);
      end
      if (prev_de && !video.de) begin
        check("de_per_line", H_ACTIVE, run);
        run = 0;
        de_lines++;
      end
      if (prev_hs && !video.hsync) hs_falls++;
      if (prev_vs && !video.vsync) vs_falls++;
      prev_de = video.de;
      prev_hs = video.hsync;
      prev_vs = video.vsync;
      @(negedge pixel_clk);
    end
    check("de_per_frame", NPIX, idx);
    check("lines_with_de", V_ACTIVE, de_lines);
    check("hsync_pulses", V_TOTAL, hs_falls);
    check("vsync_pulses", 1, vs_falls);
    for (int i = 0; i < NPIX; i++) begin
      check($sformatf("pixel_x%0d_y%0d", i % H_ACTIVE, i / H_ACTIVE), ref_fb[i], cap_fb[i]);
    end
  endtask

  // ####################################################################
  // Stimulus
  // ####################################################################

  initial begin
    int                 fd;
    int                 n;
    int                 x0;
    int                 y0;
    int                 x1;
    int                 y1;
    logic               pending;
    logic [8*128-1:0]   line_buf;
    logic [8*16-1:0]    tag;
    logic [8*16-1:0]    op_word;
    logic [8*32-1:0]    probe_name;
    logic [11:0]        color;
    gfx_pkg::draw_cmd_t c;
    rst_n   = 1'b0;
    cmd_req = 1'b0;
    cmd     = '0;
    void'($urandom(65));
    repeat (5) begin
      @(negedge pixel_clk);
      check_idle_outputs("reset");
    end
    rst_n = 1'b1;
    @(negedge pixel_clk);
    check_idle_outputs("after_reset");

    fd = $fopen("bench/gfx_input.txt", "r");
    if (fd == 0) stop_run("could not open the stimulus file bench/gfx_input.txt");
    pending  = 1'b0;
    line_buf = '0;
    while ($fgets(line_buf, fd) != 0) begin
      tag = '0;
      n   = $sscanf(line_buf, "%s", tag);
      if (n == 1 && tag == "c") begin
        n = $sscanf(line_buf, "%s %s %d %d %d %d %h", tag, op_word, x0, y0, x1, y1, color);
        if (n != 7) stop_run("malformed command line in the stimulus file");
        if (op_word == "clear") c.op = gfx_pkg::op_clear;
        else if (op_word == "fill") c.op = gfx_pkg::op_fill;
        else if (op_word == "frame") c.op = gfx_pkg::op_frame;
        else stop_run("unknown opcode in the stimulus file");
        c.x0    = x0[9:0];
        c.y0    = y0[9:0];
        c.x1    = x1[9:0];
        c.y1    = y1[9:0];
        c.color = color;
        send_command(c, paint_model(c));
        pending = 1'b1;
      end else if (n == 1 && tag == "p") begin
        n = $sscanf(line_buf, "%s %s %d %d %h", tag, probe_name, x0, y0, color);
        if (n != 5) stop_run("malformed probe line in the stimulus file");
        if (x0 >= H_ACTIVE || y0 >= V_ACTIVE) stop_run("probe lies outside the visible area");
        if (pending) begin
          capture_frame();
          pending = 1'b0;
        end
        check($sformatf("%0s", probe_name), color, cap_fb[y0 * H_ACTIVE + x0]);
      end else if (n == 1 && tag != "#") begin
        stop_run("unrecognised line in the stimulus file");
      end
      line_buf = '0;
    end
    $fclose(fd);
    if (pending) capture_frame();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/gfx_input.txt
# c <op> <x0> <y0> <x1> <y1> <rgb hex>    op is clear, fill or frame
# p <name> <x> <y> <expected rgb hex>      probes read the next frame after the commands above
c clear 0 0 0 0 123
c fill 2 3 12 10 f00
c fill 8 6 20 15 0f0
c fill 25 18 40 30 00f
p clear_corner 0 0 123
p fill_red 2 3 f00
p fill_red_only 12 5 f00
p fill_overlap 10 8 0f0
p fill_green_corner 20 15 0f0
p clip_start 25 18 00f
p clip_corner 31 23 00f
p clear_beside_clip 24 18 123
c frame 4 14 14 21 ff0
c fill 9 2 5 7 fff
c frame 22 1 40 9 0ff
c fill 3 20 6 19 f0f
p frame_top_left 4 14 ff0
p frame_bottom 9 21 ff0
p frame_right 14 17 ff0
p frame_inner_green 10 15 0f0
p frame_inner_clear 6 18 123
p empty_x_swapped 7 4 f00
p empty_y_swapped 5 19 123
p clip_frame_right 31 5 0ff
p clip_frame_top 30 1 0ff
p clip_frame_inner 27 5 123

//--- gfx_shapes_top.f
src/gfx_pkg.sv
src/vga_timing.sv
src/shape_raster.sv
src/framebuffer.sv
src/scanout.sv
src/gfx_shapes_top.sv
bench/tb_gfx_shapes.sv

//--- Makefile
# Verilator simulation of the graphics subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_gfx_shapes -f gfx_shapes_top.f
	@out="$$(./obj_dir/Vtb_gfx_shapes)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
